// ==== hdl/pps_apb_regs.sv ====
`timescale 1ns/1ps

module pps_apb_regs (
	input  logic                 clk,
	input  logic                 rst_n,
	input  pps_pkg::apb_req_t    apb_req,
	input  pps_pkg::pps_status_t status,
	output pps_pkg::apb_rsp_t    apb_rsp,
	output pps_pkg::pps_cfg_t    cfg
);

	logic        access;
	logic        wr_access;
	logic        hit_ctrl;
	logic        hit_divider;
	logic        hit_duty;
	logic        hit_offset;
	logic        hit_status;
	logic        hit_interval;
	logic        hit_count;
	logic        hit_rw;
	logic        hit_ro;
	logic        bad_access;
	logic [31:0] rd_data;

	assign access    = apb_req.psel & apb_req.penable;
	assign wr_access = access & apb_req.pwrite;

	// the whole address is compared, so unaligned offsets fall out as unmapped.
	assign hit_ctrl     = apb_req.paddr == pps_pkg::addr_ctrl;
	assign hit_divider  = apb_req.paddr == pps_pkg::addr_divider;
	assign hit_duty     = apb_req.paddr == pps_pkg::addr_duty;
	assign hit_offset   = apb_req.paddr == pps_pkg::addr_offset;
	assign hit_status   = apb_req.paddr == pps_pkg::addr_status;
	assign hit_interval = apb_req.paddr == pps_pkg::addr_interval;
	assign hit_count    = apb_req.paddr == pps_pkg::addr_count;

	assign hit_rw = hit_ctrl | hit_divider | hit_duty | hit_offset;
	assign hit_ro = hit_status | hit_interval | hit_count;

	assign bad_access = !(hit_rw | hit_ro) || (apb_req.pwrite && hit_ro);

	// writes land on the edge that closes the access phase.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg <= pps_pkg::cfg_rst;
		end else if (wr_access) begin
			if (hit_ctrl) begin
				cfg.enable <= apb_req.pwdata[pps_pkg::ctrl_enable_bit];
			end
			if (hit_divider) begin
				cfg.divider_num <= apb_req.pwdata;
			end
			if (hit_duty) begin
				cfg.duty_cnt <= apb_req.pwdata;
			end
			if (hit_offset) begin
				cfg.fwd_offset <= apb_req.pwdata;
			end
		end
	end

	// unmapped offsets read back zero along with the error.
	always_comb begin
		rd_data = '0;
		if (hit_ctrl) begin
			rd_data[pps_pkg::ctrl_enable_bit] = cfg.enable;
		end
		if (hit_divider) begin
			rd_data = cfg.divider_num;
		end
		if (hit_duty) begin
			rd_data = cfg.duty_cnt;
		end
		if (hit_offset) begin
			rd_data = cfg.fwd_offset;
		end
		if (hit_status) begin
			rd_data[pps_pkg::status_locked_bit] = status.locked;
		end
		if (hit_interval) begin
			rd_data = status.interval;
		end
		if (hit_count) begin
			rd_data = status.pps_count;
		end
	end

	// every access phase completes at once with zero wait states.
	always_comb begin
		apb_rsp.prdata  = access ? rd_data : '0;
		apb_rsp.pready  = access;
		apb_rsp.pslverr = access & bad_access;
	end

endmodule

// ==== hdl/pps_capture.sv ====
`timescale 1ns/1ps

module pps_capture #(
	parameter int cnt_w = 32
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             pps_in,
	output logic             pps_pulse,
	output logic [cnt_w-1:0] interval,
	output logic [cnt_w-1:0] pps_count
);

	logic             pps_meta;
	logic             pps_sync;
	logic             pps_sync_d;
	logic             rise;
	logic [cnt_w-1:0] cycle_cnt;

	// two flops bring the asynchronous pulse into the clk domain.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pps_meta <= 1'b0;
			pps_sync <= 1'b0;
		end else begin
			pps_meta <= pps_in;
			pps_sync <= pps_meta;
		end
	end

	assign rise = pps_sync & ~pps_sync_d;

	// the edge register also registers the strobe, so the pulse sits
	// exactly one cycle after the third sampling edge.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pps_sync_d <= 1'b0;
			pps_pulse  <= 1'b0;
		end else begin
			pps_sync_d <= pps_sync;
			pps_pulse  <= rise;
		end
	end

	// free-running count of clocks since the previous pulse or reset.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cycle_cnt <= '0;
		end else if (pps_pulse) begin
			cycle_cnt <= '0;
		end else begin
			cycle_cnt <= cycle_cnt + 1'b1;
		end
	end

	// the pulse edge itself is one of the counted clocks.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			interval  <= '0;
			pps_count <= '0;
		end else if (pps_pulse) begin
			interval  <= cycle_cnt + 1'b1;
			pps_count <= pps_count + 1'b1;
		end
	end

endmodule

// ==== hdl/pps_disciplined_gen.sv ====
`timescale 1ns/1ps

module pps_disciplined_gen #(
	parameter int cnt_w = 32
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              pps_pulse,
	input  pps_pkg::pps_cfg_t cfg,
	output logic              locked,
	output logic              sync_clk_out
);

	logic [cnt_w-1:0] divider;
	logic [cnt_w-1:0] divider_num;
	logic [cnt_w-1:0] duty_cnt;
	logic [cnt_w-1:0] fwd_offset;
	logic             realign;
	logic             wrap;
	logic             high_phase;

	assign divider_num = cnt_w'(cfg.divider_num);
	assign duty_cnt    = cnt_w'(cfg.duty_cnt);
	assign fwd_offset  = cnt_w'(cfg.fwd_offset);

	assign realign    = pps_pulse & cfg.enable;
	assign wrap       = divider >= divider_num - 1'b1; // also catches a period cut short by software.
	assign high_phase = divider < duty_cnt;

	// the divider runs all the time and is pulled into phase by each pulse.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			divider <= '0;
		end else if (realign) begin
			divider <= fwd_offset;
		end else if (wrap) begin
			divider <= '0;
		end else begin
			divider <= divider + 1'b1;
		end
	end

	// lock survives missing pulses, so the output holds over on its own.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			locked <= 1'b0;
		end else if (!cfg.enable) begin
			locked <= 1'b0;
		end else if (pps_pulse) begin
			locked <= 1'b1;
		end
	end

	// enable is checked here too, so output and lock drop on the same edge.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_clk_out <= 1'b0;
		end else begin
			sync_clk_out <= locked & cfg.enable & high_phase;
		end
	end

endmodule

// ==== hdl/pps_pkg.sv ====
package pps_pkg;

	localparam int apb_aw = 8;
	localparam int apb_dw = 32;

	// byte offsets of the registers on the APB bus.
	localparam logic [apb_aw-1:0] addr_ctrl     = 8'h00;
	localparam logic [apb_aw-1:0] addr_divider  = 8'h04;
	localparam logic [apb_aw-1:0] addr_duty     = 8'h08;
	localparam logic [apb_aw-1:0] addr_offset   = 8'h0C;
	localparam logic [apb_aw-1:0] addr_status   = 8'h10;
	localparam logic [apb_aw-1:0] addr_interval = 8'h14;
	localparam logic [apb_aw-1:0] addr_count    = 8'h18;

	// bit positions inside ctrl and status.
	localparam int ctrl_enable_bit   = 0;
	localparam int status_locked_bit = 0;

	// values the configuration registers take at reset.
	localparam logic [apb_dw-1:0] divider_rst = 32'd100;
	localparam logic [apb_dw-1:0] duty_rst    = 32'd10;
	localparam logic [apb_dw-1:0] offset_rst  = 32'd0;

	// the master drives the request side of the APB bus.
	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [apb_aw-1:0] paddr;
		logic [apb_dw-1:0] pwdata;
	} apb_req_t;

	// the slave drives the response side of the APB bus.
	typedef struct packed {
		logic [apb_dw-1:0] prdata;
		logic              pready;
		logic              pslverr;
	} apb_rsp_t;

	// configuration seen by the clock generator.
	typedef struct packed {
		logic              enable;
		logic [apb_dw-1:0] divider_num; // output period in system clocks.
		logic [apb_dw-1:0] duty_cnt; // output high time in system clocks.
		logic [apb_dw-1:0] fwd_offset; // divider value loaded on a PPS edge.
	} pps_cfg_t;

	// status gathered from capture and generator.
	typedef struct packed {
		logic              locked;
		logic [apb_dw-1:0] interval; // clocks between the last two pulses.
		logic [apb_dw-1:0] pps_count; // pulses seen since reset.
	} pps_status_t;

	// reset image of the configuration registers.
	localparam pps_cfg_t cfg_rst = '{
		enable:      1'b0,
		divider_num: divider_rst,
		duty_cnt:    duty_rst,
		fwd_offset:  offset_rst
	};

endpackage

// ==== hdl/pps_sync_top.sv ====
`timescale 1ns/1ps

module pps_sync_top #(
	parameter int cnt_w = 32
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              pps_in,
	input  pps_pkg::apb_req_t apb_req,
	output pps_pkg::apb_rsp_t apb_rsp,
	output logic              sync_clk_out,
	output logic              locked
);

	logic                 pps_pulse;
	logic [cnt_w-1:0]     interval;
	logic [cnt_w-1:0]     pps_count;
	pps_pkg::pps_cfg_t    cfg;
	pps_pkg::pps_status_t status;

	// counters narrower than the bus are zero extended.
	assign status.locked    = locked;
	assign status.interval  = 32'(interval);
	assign status.pps_count = 32'(pps_count);

	pps_capture #(
		.cnt_w (cnt_w)
	) i_capture (
		.clk       (clk),
		.rst_n     (rst_n),
		.pps_in    (pps_in),
		.pps_pulse (pps_pulse),
		.interval  (interval),
		.pps_count (pps_count)
	);

	pps_disciplined_gen #(
		.cnt_w (cnt_w)
	) i_gen (
		.clk          (clk),
		.rst_n        (rst_n),
		.pps_pulse    (pps_pulse),
		.cfg          (cfg),
		.locked       (locked),
		.sync_clk_out (sync_clk_out)
	);

	pps_apb_regs i_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.apb_req (apb_req),
		.status  (status),
		.apb_rsp (apb_rsp),
		.cfg     (cfg)
	);

endmodule

// ==== project.f ====
hdl/pps_pkg.sv
hdl/pps_capture.sv
hdl/pps_disciplined_gen.sv
hdl/pps_apb_regs.sv
hdl/pps_sync_top.sv
sim/pps_sync_props.sv
sim/pps_sync_tb.sv

// ==== sim/pps_sync_props.sv ====
`timescale 1ns/1ps

module pps_gen_props #(
	parameter int cnt_w = 32
) (
	input logic             clk,
	input logic             rst_n,
	input logic             pps_pulse,
	input logic             locked,
	input logic             sync_clk_out,
	input logic [cnt_w-1:0] divider,
	input logic [cnt_w-1:0] divider_num
);

	// the output clock is gated by lock.
	assert property (@(posedge clk) disable iff (!rst_n) !locked |-> !sync_clk_out)
		else $error("sync_clk_out is high while unlocked");

	assert property (@(posedge clk) disable iff (!rst_n) $rose(locked) |-> $past(pps_pulse))
		else $error("locked rose without a PPS pulse in the cycle before");

	// a period shortened by software needs one edge to wrap.
	assert property (@(posedge clk) disable iff (!rst_n)
			$stable(divider_num) |-> divider < divider_num)
		else $error("divider is beyond divider_num - 1");

endmodule

bind pps_disciplined_gen pps_gen_props #(
	.cnt_w (cnt_w)
) i_props (
	.clk          (clk),
	.rst_n        (rst_n),
	.pps_pulse    (pps_pulse),
	.locked       (locked),
	.sync_clk_out (sync_clk_out),
	.divider      (divider),
	.divider_num  (divider_num)
);

// ==== sim/pps_sync_tb.sv ====
`timescale 1ns/1ps

module pps_sync_tb;

	localparam int cnt_w    = 32;
	localparam int wait_max = 2000; // clocks any single wait may take.
	localparam int pps_high = 3;

	logic              clk;
	logic              rst_n;
	logic              pps_in;
	pps_pkg::apb_req_t apb_req;
	pps_pkg::apb_rsp_t apb_rsp;
	logic              sync_clk_out;
	logic              locked;
	int unsigned       cycle_no = 0; // rising edges since time zero.
	int unsigned       prev_edge = 0; // sampling edge of the last pulse.
	int unsigned       pulse_total = 0;
	logic [31:0]       lcg_state = 32'h3eb2;

	pps_sync_top #(
		.cnt_w (cnt_w)
	) i_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.pps_in       (pps_in),
		.apb_req      (apb_req),
		.apb_rsp      (apb_rsp),
		.sync_clk_out (sync_clk_out),
		.locked       (locked)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_no <= cycle_no + 1;
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// the load rule of the divider predicts the first rise after a realign.
	function automatic int unsigned predicted_rise(input int unsigned edge_e,
			input int unsigned period, input int unsigned high, input int unsigned offset);
		if (offset < high) begin
			return edge_e + 4;
		end
		return edge_e + 4 + (period - offset);
	endfunction

	task automatic abort_run();
		$display("Regression failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_cfg_word(input string name, input logic [pps_pkg::apb_dw-1:0] expected,
			input logic [pps_pkg::apb_dw-1:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] time=%0t %s expected=0x%08h actual=0x%08h",
				$time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("[ERROR] time=%0t %s expected=%b actual=%b", $time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_status(input pps_pkg::pps_status_t expected,
			input pps_pkg::pps_status_t actual);
		check_bit("status.locked", expected.locked, actual.locked);
		check_cfg_word("status.interval", expected.interval, actual.interval);
		check_cfg_word("status.pps_count", expected.pps_count, actual.pps_count);
	endtask

	task automatic wait_until_cycle(input int unsigned target);
		int unsigned waited;
		waited = 0;
		while (cycle_no < target) begin
			@(negedge clk);
			waited++;
			if (waited > wait_max) begin
				$display("timeout waiting for clock cycle %0d", target);
				abort_run();
			end
		end
	endtask

	task automatic wait_level(input logic level, output int unsigned at);
		int unsigned waited;
		waited = 0;
		while (sync_clk_out !== level) begin
			@(negedge clk);
			waited++;
			if (waited > wait_max) begin
				$display("timeout waiting for sync_clk_out to reach %b", level);
				abort_run();
			end
		end
		at = cycle_no;
	endtask

	task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic slverr);
		int unsigned waited;
		waited = 0;
		@(negedge clk);
		apb_req.psel    = 1'b1; // setup phase.
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(negedge clk);
		apb_req.penable = 1'b1;
		@(posedge clk);
		while (apb_rsp.pready !== 1'b1) begin
			waited++;
			if (waited > wait_max) begin
				$display("APB access to address 0x%02h never got pready", addr);
				abort_run();
			end
			@(posedge clk);
		end
		rdata  = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		@(negedge clk);
		apb_req = '0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
		logic [31:0] unused;
		logic        err;
		apb_access(1'b1, addr, data, unused, err);
		check_bit("pslverr", exp_err, err);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, input logic exp_err);
		logic err;
		apb_access(1'b0, addr, 32'd0, data, err);
		check_bit("pslverr", exp_err, err);
	endtask

	task automatic read_status(output pps_pkg::pps_status_t status);
		logic [31:0] data;
		apb_read(pps_pkg::addr_status, data, 1'b0);
		status.locked = data[0];
		apb_read(pps_pkg::addr_interval, data, 1'b0);
		status.interval = data;
		apb_read(pps_pkg::addr_count, data, 1'b0);
		status.pps_count = data;
	endtask

	task automatic set_config(input int unsigned period, input int unsigned high,
			input int unsigned offset, input logic enable);
		apb_write(pps_pkg::addr_divider, period, 1'b0);
		apb_write(pps_pkg::addr_duty, high, 1'b0);
		apb_write(pps_pkg::addr_offset, offset, 1'b0);
		apb_write(pps_pkg::addr_ctrl, {31'd0, enable}, 1'b0);
	endtask

	// pps_in is first sampled high at edge_e.
	task automatic drive_pps(input int unsigned edge_e);
		if (cycle_no >= edge_e) begin
			$display("PPS edge %0d was requested after it had passed", edge_e);
			abort_run();
		end
		wait_until_cycle(edge_e - 1);
		pps_in = 1'b1;
		repeat (pps_high) @(negedge clk);
		pps_in = 1'b0;
		prev_edge = edge_e;
		pulse_total++;
	endtask

	task automatic check_quiet(input int unsigned cycles);
		repeat (cycles) begin
			@(negedge clk);
			check_bit("locked", 1'b0, locked);
			check_bit("sync_clk_out", 1'b0, sync_clk_out);
		end
	endtask

	task automatic measure_periods(input int unsigned count, input int unsigned period,
			input int unsigned high);
		int unsigned rise;
		int unsigned fall;
		int unsigned next_rise;
		wait_level(1'b0, fall);
		wait_level(1'b1, rise); // rises only where the divider restarts at 0.
		repeat (count) begin
			wait_level(1'b0, fall);
			check_cfg_word("high time", high, fall - rise);
			wait_level(1'b1, next_rise);
			check_cfg_word("period", period, next_rise - rise);
			rise = next_rise;
		end
	endtask

	task automatic test_register_access();
		logic [31:0]          data;
		pps_pkg::pps_status_t observed;
		apb_read(pps_pkg::addr_ctrl, data, 1'b0);
		check_cfg_word("ctrl", 32'd0, data);
		apb_read(pps_pkg::addr_divider, data, 1'b0);
		check_cfg_word("divider", 32'd100, data);
		apb_read(pps_pkg::addr_duty, data, 1'b0);
		check_cfg_word("duty", 32'd10, data);
		apb_read(pps_pkg::addr_offset, data, 1'b0);
		check_cfg_word("offset", 32'd0, data);
		read_status(observed);
		check_status('{locked: 1'b0, interval: 32'd0, pps_count: 32'd0}, observed);
		apb_write(pps_pkg::addr_ctrl, 32'd1, 1'b0);
		apb_read(pps_pkg::addr_ctrl, data, 1'b0);
		check_cfg_word("ctrl", 32'd1, data);
		apb_write(pps_pkg::addr_ctrl, 32'd0, 1'b0);
		apb_write(pps_pkg::addr_divider, 32'h0000_3a5c, 1'b0);
		apb_read(pps_pkg::addr_divider, data, 1'b0);
		check_cfg_word("divider", 32'h0000_3a5c, data);
		apb_write(pps_pkg::addr_duty, 32'h0000_0123, 1'b0);
		apb_read(pps_pkg::addr_duty, data, 1'b0);
		check_cfg_word("duty", 32'h0000_0123, data);
		apb_write(pps_pkg::addr_offset, 32'h0000_0042, 1'b0);
		apb_read(pps_pkg::addr_offset, data, 1'b0);
		check_cfg_word("offset", 32'h0000_0042, data);
		apb_read(8'h1c, data, 1'b1);
		apb_write(8'h40, 32'hffff_ffff, 1'b1);
		apb_write(pps_pkg::addr_status, 32'hffff_ffff, 1'b1);
		apb_write(pps_pkg::addr_count, 32'h0000_0055, 1'b1);
		read_status(observed);
		check_status('{locked: 1'b0, interval: 32'd0, pps_count: 32'd0}, observed);
		apb_read(pps_pkg::addr_ctrl, data, 1'b0);
		check_cfg_word("ctrl", 32'd0, data);
		apb_read(pps_pkg::addr_duty, data, 1'b0);
		check_cfg_word("duty", 32'h0000_0123, data);
	endtask

	task automatic test_lock_and_phase();
		logic [31:0] data;
		int unsigned edge_e;
		int unsigned rise;
		set_config(20, 5, 0, 1'b1);
		check_quiet(30);
		apb_read(pps_pkg::addr_status, data, 1'b0);
		check_cfg_word("status", 32'd0, data);
		edge_e = cycle_no + 2;
		drive_pps(edge_e);
		wait_level(1'b1, rise);
		check_cfg_word("first rise cycle", edge_e + 4, rise);
		apb_read(pps_pkg::addr_status, data, 1'b0);
		check_cfg_word("status", 32'd1, data);
	endtask

	task automatic test_period_and_duty();
		int unsigned edge_e;
		int unsigned rise;
		apb_write(pps_pkg::addr_duty, 32'd6, 1'b0);
		apb_write(pps_pkg::addr_divider, 32'd16, 1'b0);
		measure_periods(4, 16, 6);
		apb_write(pps_pkg::addr_ctrl, 32'd0, 1'b0); // start unlocked for the offset case.
		set_config(20, 5, 12, 1'b1);
		edge_e = cycle_no + 2;
		drive_pps(edge_e);
		wait_level(1'b1, rise);
		check_cfg_word("offset rise cycle", predicted_rise(edge_e, 20, 5, 12), rise);
		measure_periods(2, 20, 5);
	endtask

	task automatic test_interval_measurement();
		int unsigned          spacing;
		int unsigned          edge_e;
		pps_pkg::pps_status_t observed;
		apb_write(pps_pkg::addr_offset, 32'd0, 1'b0);
		drive_pps(cycle_no + 2); // reference pulse for the first spacing.
		repeat (5) begin
			spacing = 40 + next_random() % 32'd80;
			edge_e = prev_edge + spacing;
			drive_pps(edge_e);
			wait_until_cycle(edge_e + 4);
			read_status(observed);
			check_status('{locked: 1'b1, interval: spacing, pps_count: pulse_total}, observed);
		end
	endtask

	task automatic test_holdover_and_realign();
		logic [31:0] data;
		int unsigned edge_e;
		int unsigned rise;
		int unsigned fall;
		int unsigned next_rise;
		measure_periods(6, 20, 5);
		check_bit("locked", 1'b1, locked);
		apb_read(pps_pkg::addr_status, data, 1'b0);
		check_cfg_word("status", 32'd1, data);
		// the pulse lands nine clocks off the running phase while the output is low.
		edge_e = prev_edge + 20 * ((cycle_no - prev_edge) / 20 + 2) + 9;
		drive_pps(edge_e);
		wait_until_cycle(edge_e + 3);
		check_bit("sync_clk_out", 1'b0, sync_clk_out);
		wait_level(1'b1, rise);
		check_cfg_word("realigned rise cycle", predicted_rise(edge_e, 20, 5, 0), rise);
		wait_level(1'b0, fall);
		check_cfg_word("high time", 32'd5, fall - rise);
		wait_level(1'b1, next_rise);
		check_cfg_word("period", 32'd20, next_rise - rise);
	endtask

	task automatic test_disable();
		logic [31:0] data;
		int unsigned edge_e;
		int unsigned rise;
		apb_write(pps_pkg::addr_ctrl, 32'd0, 1'b0);
		check_quiet(40);
		apb_write(pps_pkg::addr_ctrl, 32'd1, 1'b0);
		check_quiet(60);
		apb_read(pps_pkg::addr_status, data, 1'b0);
		check_cfg_word("status", 32'd0, data);
		edge_e = cycle_no + 2;
		drive_pps(edge_e);
		wait_until_cycle(edge_e + 3);
		check_bit("locked", 1'b1, locked);
		wait_level(1'b1, rise);
		check_cfg_word("relock rise cycle", edge_e + 4, rise);
	endtask

	initial begin
		rst_n   = 1'b0;
		pps_in  = 1'b0;
		apb_req = '0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		test_register_access();
		test_lock_and_phase();
		test_period_and_duty();
		test_interval_measurement();
		test_holdover_and_realign();
		test_disable();
		$display("Regression passed");
		$finish;
	end

endmodule
